//--- include/ata_defines.svh
// ATA host controller sizes and PIO strobe timing
// shared by the sector buffer, its ATA port and the transfer engine

`ifndef ATA_DEFINES_SVH
`define ATA_DEFINES_SVH

// sector buffer geometry, 4 KB seen two ways
// bus side is 1024 words of 32 bits
`define ATA_BUF_BUS_AW 10
// ATA side is 2048 words of 16 bits
`define ATA_BUF_ATA_AW 11

// PIO strobe timing, counted in clk cycles

// cycles a read or write strobe stays low
`define ATA_T_ACTIVE 4

// cycles with both strobes high before the next word
`define ATA_T_RECOVER 3

`endif

//--- design/bus_pkg.sv
// Processor-side definitions of the ATA host controller
// register map index and the layout of the status word

package bus_pkg;

  // register index, taken from bus word address bits 4 to 2
  typedef enum logic [2:0] {
    REG_CTRL   = 3'd0, // bit 0 starts, bit 1 selects direction
    REG_COUNT  = 3'd1, // number of 16-bit words to move
    REG_STATUS = 3'd2  // busy and sticky done
  } reg_idx_e;

  // status word as it appears on the bus
  typedef struct packed {
    logic [29:0] rsvd; // reads as zero
    logic        done; // set when a transfer ends, cleared by a write
    logic        busy; // engine is moving words
  } status_t;

endpackage

//--- design/ata_pkg.sv
// Drive-side definitions of the ATA host controller
// transfer direction and the states of the PIO transfer engine

package ata_pkg;

  // direction as seen from the drive
  typedef enum logic {
    DIR_FROM_DRIVE = 1'b0, // strobe dior_n, fill the buffer
    DIR_TO_DRIVE   = 1'b1  // strobe diow_n, empty the buffer
  } xfer_dir_e;

  // PIO engine states, one word passes FETCH (writes only),
  // ACTIVE and RECOVER in that order
  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    FETCH   = 2'd1,
    ACTIVE  = 2'd2,
    RECOVER = 2'd3
  } pio_state_e;

endpackage

//--- design/ata_buf_if.sv
// ATA-side port of the sector buffer
// the transfer engine addresses 16-bit words, read data follows one cycle later

`timescale 1ns/1ns

`include "ata_defines.svh"

interface ata_buf_if;

  logic                       write; // writes wdata at addr in this cycle
  logic [`ATA_BUF_ATA_AW-1:0] addr;  // ATA word index
  logic [15:0]                wdata;
  logic [15:0]                rdata; // word at the addr of the previous cycle

  modport xfer (
    output write,
    output addr,
    output wdata,
    input  rdata
  );

  modport buffer (
    input  write,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

//--- design/ata_cfg_if.sv
// Control path from the register block to the PIO transfer engine
// start, direction and count one way, busy and done the other

`timescale 1ns/1ns

interface ata_cfg_if;

  logic                 start;      // one-cycle request
  ata_pkg::xfer_dir_e   dir;        // valid while start is high
  logic [11:0]          count;      // 1 to 2048 words
  logic                 busy;
  logic                 done_pulse; // high in the last cycle of a transfer

  modport regs (
    output start,
    output dir,
    output count,
    input  busy,
    input  done_pulse
  );

  modport xfer (
    input  start,
    input  dir,
    input  count,
    output busy,
    output done_pulse
  );

endinterface

//--- design/ata_buffer.sv
// ATA sector buffer, 4 KB dual port
// 32-bit bus port with byte-swapped lanes, 16-bit ATA port over hi and lo halves

`timescale 1ns/1ns

`include "ata_defines.svh"

module ata_buffer (
  input  logic                       clk,
  input  logic                       bus_write,
  input  logic [`ATA_BUF_BUS_AW-1:0] bus_addr,
  input  logic [31:0]                bus_din,
  output logic [31:0]                bus_dout,
  ata_buf_if.buffer                  ata
);

  localparam int DEPTH = 1 << `ATA_BUF_BUS_AW;

  // hi holds even ATA words, lo holds odd ones
  logic [15:0] hi_mem [DEPTH];
  logic [15:0] lo_mem [DEPTH];

  logic [`ATA_BUF_BUS_AW-1:0] ata_idx;
  logic [15:0]                hi_bus_din;
  logic [15:0]                lo_bus_din;
  logic                       hi_ata_write;
  logic                       lo_ata_write;
  logic [15:0]                hi_bus_q;
  logic [15:0]                lo_bus_q;
  logic [15:0]                hi_ata_q;
  logic [15:0]                lo_ata_q;
  logic                       ata_sel_q;

  assign ata_idx = ata.addr[`ATA_BUF_ATA_AW-1:1]; // word pair shared by hi and lo

  // the drive sends the low byte first, the bus is big-endian
  assign hi_bus_din = {bus_din[23:16], bus_din[31:24]};
  assign lo_bus_din = {bus_din[7:0], bus_din[15:8]};

  assign hi_ata_write = ata.write & ~ata.addr[0];
  assign lo_ata_write = ata.write & ata.addr[0];

  always_ff @(posedge clk) begin
    if (bus_write) begin
      hi_mem[bus_addr] <= hi_bus_din;
      lo_mem[bus_addr] <= lo_bus_din;
    end
    if (hi_ata_write) begin
      hi_mem[ata_idx] <= ata.wdata;
    end
    if (lo_ata_write) begin
      lo_mem[ata_idx] <= ata.wdata;
    end
    hi_bus_q  <= hi_mem[bus_addr];
    lo_bus_q  <= lo_mem[bus_addr];
    hi_ata_q  <= hi_mem[ata_idx];
    lo_ata_q  <= lo_mem[ata_idx];
    ata_sel_q <= ata.addr[0]; // picks the half that the read data belongs to
  end

  assign bus_dout  = {hi_bus_q[7:0], hi_bus_q[15:8], lo_bus_q[7:0], lo_bus_q[15:8]};
  assign ata.rdata = ata_sel_q ? lo_ata_q : hi_ata_q;

  // a bus write covers both halves, so any ATA write to the same pair collides
  a_no_write_collision: assert property (
    @(posedge clk) !(bus_write && ata.write && (bus_addr == ata_idx))
  ) else $error("bus and ATA port write buffer index %0h in the same cycle", ata_idx);

endmodule

//--- design/ata_regs.sv
// ATA host register block and bus decoder
// routes bus accesses to the buffer or the registers and drives the transfer engine

`timescale 1ns/1ns

module ata_regs (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        bus_en,
  input  logic        bus_write,
  input  logic [12:2] bus_addr,
  input  logic [31:0] bus_din,
  output logic [31:0] bus_dout,
  output logic        buf_write,
  input  logic [31:0] buf_rdata,
  ata_cfg_if.regs     cfg
);

  bus_pkg::reg_idx_e  reg_idx;
  bus_pkg::status_t   status;
  logic               reg_write;
  logic               reg_read;
  logic               ctrl_write;
  ata_pkg::xfer_dir_e dir_q;
  logic [11:0]        count_q;
  logic               done_q;
  logic               rd_reg_q;
  logic [31:0]        reg_rdata_d;
  logic [31:0]        reg_rdata_q;

  assign reg_idx    = bus_pkg::reg_idx_e'(bus_addr[4:2]);
  assign reg_write  = bus_en & bus_write & bus_addr[12];
  assign reg_read   = bus_en & ~bus_write & bus_addr[12];
  assign buf_write  = bus_en & bus_write & ~bus_addr[12];
  assign ctrl_write = reg_write & (reg_idx == bus_pkg::REG_CTRL);

  // start goes out in the write cycle itself so busy can follow one cycle later
  assign cfg.start = ctrl_write & bus_din[0];
  assign cfg.dir   = ctrl_write ? ata_pkg::xfer_dir_e'(bus_din[1]) : dir_q;
  assign cfg.count = count_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dir_q    <= ata_pkg::DIR_FROM_DRIVE;
      count_q  <= '0;
      done_q   <= 1'b0;
      rd_reg_q <= 1'b0;
    end else begin
      if (ctrl_write) begin
        dir_q <= ata_pkg::xfer_dir_e'(bus_din[1]);
      end
      if (reg_write && (reg_idx == bus_pkg::REG_COUNT)) begin
        count_q <= bus_din[11:0];
      end
      if (cfg.done_pulse) begin
        done_q <= 1'b1; // a finishing transfer wins over a clearing write
      end else if (reg_write && (reg_idx == bus_pkg::REG_STATUS)) begin
        done_q <= 1'b0;
      end
      if (bus_en && !bus_write) begin
        rd_reg_q <= bus_addr[12];
      end
    end
  end

  always_comb begin
    status      = '0;
    status.busy = cfg.busy;
    status.done = done_q;
    case (reg_idx)
      bus_pkg::REG_CTRL:   reg_rdata_d = {30'd0, dir_q, 1'b0};
      bus_pkg::REG_COUNT:  reg_rdata_d = {20'd0, count_q};
      bus_pkg::REG_STATUS: reg_rdata_d = status;
      default:             reg_rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reg_read) begin
      reg_rdata_q <= reg_rdata_d;
    end
  end

  // buffer read data is already registered inside the buffer
  assign bus_dout = rd_reg_q ? reg_rdata_q : buf_rdata;

  // the bus master leaves a gap between two control writes
  a_start_single: assert property (
    @(posedge clk) disable iff (!arst_n) cfg.start |=> !cfg.start
  ) else $error("start pulsed in two consecutive cycles");

endmodule

//--- design/ata_pio_xfer.sv
// ATA PIO transfer engine
// sequences dior_n and diow_n and moves 16-bit words between drive and buffer

`timescale 1ns/1ns

`include "ata_defines.svh"

module ata_pio_xfer (
  input  logic        clk,
  input  logic        arst_n,
  ata_cfg_if.xfer     cfg,
  ata_buf_if.xfer     bufp,
  output logic [15:0] dd_out,
  input  logic [15:0] dd_in,
  output logic        dd_oe,
  output logic        dior_n,
  output logic        diow_n
);

  localparam int CYC_W = $clog2(`ATA_T_ACTIVE + `ATA_T_RECOVER);
  localparam logic [CYC_W-1:0] ACT_LAST = CYC_W'(`ATA_T_ACTIVE - 1);
  localparam logic [CYC_W-1:0] REC_LAST = CYC_W'(`ATA_T_RECOVER - 1);

  ata_pkg::pio_state_e        state_q, state_d;
  ata_pkg::xfer_dir_e         dir_q, dir_d;
  logic [`ATA_BUF_ATA_AW-1:0] word_q, word_d;
  logic [`ATA_BUF_ATA_AW-1:0] last_q, last_d;
  logic [CYC_W-1:0]           cyc_q, cyc_d;
  logic                       to_drive;
  logic                       last_rec;
  logic [15:0]                data_q;

  assign to_drive = (dir_q == ata_pkg::DIR_TO_DRIVE);
  assign last_rec = (state_q == ata_pkg::RECOVER) && (cyc_q == REC_LAST);

  always_comb begin
    state_d = state_q;
    dir_d   = dir_q;
    word_d  = word_q;
    last_d  = last_q;
    cyc_d   = cyc_q;
    case (state_q)
      ata_pkg::IDLE: begin
        if (cfg.start) begin
          dir_d   = cfg.dir;
          last_d  = cfg.count[`ATA_BUF_ATA_AW-1:0] - 1'b1; // count of 2048 wraps to 0
          word_d  = '0;
          cyc_d   = '0;
          state_d = (cfg.dir == ata_pkg::DIR_TO_DRIVE) ? ata_pkg::FETCH : ata_pkg::ACTIVE;
        end
      end
      ata_pkg::FETCH: begin
        state_d = ata_pkg::ACTIVE;
        cyc_d   = '0;
      end
      ata_pkg::ACTIVE: begin
        if (cyc_q == ACT_LAST) begin
          state_d = ata_pkg::RECOVER;
          cyc_d   = '0;
        end else begin
          cyc_d = cyc_q + 1'b1;
        end
      end
      default: begin
        if (cyc_q != REC_LAST) begin
          cyc_d = cyc_q + 1'b1;
        end else if (word_q == last_q) begin
          state_d = ata_pkg::IDLE;
        end else begin
          word_d  = word_q + 1'b1;
          cyc_d   = '0;
          state_d = to_drive ? ata_pkg::FETCH : ata_pkg::ACTIVE;
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= ata_pkg::IDLE;
      dir_q   <= ata_pkg::DIR_FROM_DRIVE;
      word_q  <= '0;
      last_q  <= '0;
      cyc_q   <= '0;
      dior_n  <= 1'b1;
      diow_n  <= 1'b1;
      dd_oe   <= 1'b0;
    end else begin
      state_q <= state_d;
      dir_q   <= dir_d;
      word_q  <= word_d;
      last_q  <= last_d;
      cyc_q   <= cyc_d;
      // strobes come from the next state, so they line up with ACTIVE
      dior_n  <= !((state_d == ata_pkg::ACTIVE) && (dir_d == ata_pkg::DIR_FROM_DRIVE));
      diow_n  <= !((state_d == ata_pkg::ACTIVE) && (dir_d == ata_pkg::DIR_TO_DRIVE));
      dd_oe   <= (state_d == ata_pkg::ACTIVE) && (dir_d == ata_pkg::DIR_TO_DRIVE);
    end
  end

  // drive data is sampled at the end of the last strobe cycle
  always_ff @(posedge clk) begin
    if ((state_q == ata_pkg::ACTIVE) && (cyc_q == ACT_LAST) && !to_drive) begin
      data_q <= dd_in;
    end
  end

  assign bufp.addr  = word_q; // held for the whole word so rdata stays put
  assign bufp.wdata = data_q;
  assign bufp.write = (state_q == ata_pkg::RECOVER) && (cyc_q == '0) && !to_drive;

  assign dd_out = bufp.rdata;

  assign cfg.busy       = (state_q != ata_pkg::IDLE);
  assign cfg.done_pulse = last_rec && (word_q == last_q);

  a_strobe_excl: assert property (
    @(posedge clk) disable iff (!arst_n) !(!dior_n && !diow_n)
  ) else $error("dior_n and diow_n low together");

  // the drive bus is only driven inside a write strobe of a running transfer
  a_oe_in_write: assert property (
    @(posedge clk) disable iff (!arst_n)
    dd_oe |-> (!diow_n && (state_q == ata_pkg::ACTIVE))
  ) else $error("dd_oe high outside a write strobe, state %0d", state_q);

endmodule

//--- design/ata_ctrl_top.sv
// ATA PIO host controller data path
// register block, sector buffer and transfer engine behind a 32-bit bus

`timescale 1ns/1ns

`include "ata_defines.svh"

module ata_ctrl_top (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        bus_en,
  input  logic        bus_write,
  input  logic [12:2] bus_addr,
  input  logic [31:0] bus_din,
  output logic [31:0] bus_dout,
  output logic [15:0] dd_out,
  input  logic [15:0] dd_in,
  output logic        dd_oe,
  output logic        dior_n,
  output logic        diow_n
);

  logic        buf_write;
  logic [31:0] buf_rdata;

  ata_buf_if buf_if ();
  ata_cfg_if cfg_if ();

  ata_regs u_regs (
    .clk       (clk),
    .arst_n    (arst_n),
    .bus_en    (bus_en),
    .bus_write (bus_write),
    .bus_addr  (bus_addr),
    .bus_din   (bus_din),
    .bus_dout  (bus_dout),
    .buf_write (buf_write),
    .buf_rdata (buf_rdata),
    .cfg       (cfg_if.regs)
  );

  ata_buffer u_buffer (
    .clk       (clk),
    .bus_write (buf_write),
    .bus_addr  (bus_addr[`ATA_BUF_BUS_AW+1:2]),
    .bus_din   (bus_din),
    .bus_dout  (buf_rdata),
    .ata       (buf_if.buffer)
  );

  ata_pio_xfer u_xfer (
    .clk    (clk),
    .arst_n (arst_n),
    .cfg    (cfg_if.xfer),
    .bufp   (buf_if.xfer),
    .dd_out (dd_out),
    .dd_in  (dd_in),
    .dd_oe  (dd_oe),
    .dior_n (dior_n),
    .diow_n (diow_n)
  );

endmodule

//--- sim/ata_drive_model.sv
// Behavioral ATA drive for the controller testbench
// captures words on write strobes and returns preloaded words on read strobes

`timescale 1ns/1ns

module ata_drive_model (
  input  logic [15:0] dd_out,
  output logic [15:0] dd_in,
  input  logic        dior_n,
  input  logic        diow_n
);

  logic [15:0] wr_mem [2048]; // words received from the host
  logic [15:0] rd_mem [2048]; // words handed to the host
  logic [10:0] wr_idx;
  logic [10:0] rd_idx;
  int          wr_total;
  int          rd_total;
  logic        idx_clr = 1'b0;

  assign dd_in = dior_n ? 16'h0000 : rd_mem[rd_idx]; // next word while the read strobe is low

  always @(posedge diow_n or posedge idx_clr) begin
    if (idx_clr) begin
      wr_idx   <= '0;
      wr_total <= 0;
    end else begin
      wr_mem[wr_idx] <= dd_out; // data is still held when the strobe rises
      wr_idx         <= wr_idx + 1'b1;
      wr_total       <= wr_total + 1;
    end
  end

  always @(posedge dior_n or posedge idx_clr) begin
    if (idx_clr) begin
      rd_idx   <= '0;
      rd_total <= 0;
    end else begin
      rd_idx   <= rd_idx + 1'b1;
      rd_total <= rd_total + 1;
    end
  end

  task automatic reset_index();
    idx_clr = 1'b1;
    #1;
    idx_clr = 1'b0;
  endtask

  task automatic load_word(input int i, input logic [15:0] w);
    rd_mem[i[10:0]] = w;
  endtask

  function automatic logic [15:0] stored_word(input int i);
    return wr_mem[i[10:0]];
  endfunction

  function automatic int words_written();
    return wr_total;
  endfunction

  function automatic int words_read();
    return rd_total;
  endfunction

endmodule

//--- sim/tb_ata_ctrl.sv
// Directed testbench for the ATA PIO host controller
// checks reset state, buffer access, both transfer directions and status

`timescale 1ns/1ns

`include "ata_defines.svh"

module tb_ata_ctrl;

  localparam int MAX_CYCLES = 4 * 2048 * 9 + 1000; // worst case of four full transfers

  logic        clk;
  logic        arst_n;
  logic        bus_en;
  logic        bus_write;
  logic [12:2] bus_addr;
  logic [31:0] bus_din;
  logic [31:0] bus_dout;
  logic [15:0] dd_out;
  logic [15:0] dd_in;
  logic        dd_oe;
  logic        dior_n;
  logic        diow_n;
  integer      seed = 32'hfe8a;
  int          cycles = 0;
  int          rd_low = 0;
  int          wr_low = 0;
  int          wr_strobes = 0;
  logic [31:0] bus_words [64];
  logic [15:0] drive_words [128];

  ata_ctrl_top u_dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .bus_en    (bus_en),
    .bus_write (bus_write),
    .bus_addr  (bus_addr),
    .bus_din   (bus_din),
    .bus_dout  (bus_dout),
    .dd_out    (dd_out),
    .dd_in     (dd_in),
    .dd_oe     (dd_oe),
    .dior_n    (dior_n),
    .diow_n    (diow_n)
  );

  ata_drive_model u_model (
    .dd_out (dd_out),
    .dd_in  (dd_in),
    .dior_n (dior_n),
    .diow_n (diow_n)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic abort_run();
    $display("Something failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("run did not finish within %0d cycles", MAX_CYCLES);
      abort_run();
    end
  end

  // strobe widths, counted in whole cycles at the falling edge
  always @(negedge clk) begin
    if (arst_n === 1'b1) begin
      check_value("dd_oe", 32'(dd_oe), 32'(!diow_n)); // data bus driven only inside a write strobe
      if (diow_n === 1'b0) begin
        wr_low = wr_low + 1;
      end else if (wr_low != 0) begin
        check_value("diow_n low cycles", 32'(wr_low), 32'(`ATA_T_ACTIVE));
        wr_strobes = wr_strobes + 1;
        wr_low = 0;
      end
      if (dior_n === 1'b0) begin
        rd_low = rd_low + 1;
      end else if (rd_low != 0) begin
        check_value("dior_n low cycles", 32'(rd_low), 32'(`ATA_T_ACTIVE));
        rd_low = 0;
      end
    end
  end

  function automatic logic [31:0] next_random();
    return $random(seed);
  endfunction

  function automatic logic [15:0] swap_bytes(input logic [15:0] w);
    return {w[7:0], w[15:8]};
  endfunction

  function automatic logic [10:0] reg_addr(input bus_pkg::reg_idx_e idx);
    return {1'b1, 7'd0, idx};
  endfunction

  // bus tasks start and end right after a falling edge
  task automatic bus_put(input logic [10:0] addr, input logic [31:0] data);
    bus_en    = 1'b1;
    bus_write = 1'b1;
    bus_addr  = addr;
    bus_din   = data;
    @(negedge clk);
    bus_en    = 1'b0;
    bus_write = 1'b0;
  endtask

  task automatic bus_get(input logic [10:0] addr, output logic [31:0] data);
    bus_en    = 1'b1;
    bus_write = 1'b0;
    bus_addr  = addr;
    @(negedge clk);
    data   = bus_dout; // registered at the edge in between
    bus_en = 1'b0;
  endtask

  task automatic start_transfer(input int count, input ata_pkg::xfer_dir_e dir);
    bus_put(reg_addr(bus_pkg::REG_COUNT), 32'(count));
    bus_put(reg_addr(bus_pkg::REG_CTRL), {30'd0, dir, 1'b1});
  endtask

  task automatic wait_idle();
    logic [31:0] st;
    bus_get(reg_addr(bus_pkg::REG_STATUS), st);
    while (st[0]) begin
      bus_get(reg_addr(bus_pkg::REG_STATUS), st);
    end
  endtask

  task automatic test_reset_state();
    logic [31:0] st;
    check_value("dior_n", 32'(dior_n), 32'h1);
    check_value("diow_n", 32'(diow_n), 32'h1);
    check_value("dd_oe", 32'(dd_oe), 32'h0);
    bus_get(reg_addr(bus_pkg::REG_STATUS), st);
    check_value("status", st, 32'h0);
  endtask

  task automatic test_buffer_round_trip();
    logic [9:0]  addrs [8];
    logic [31:0] data [8];
    logic [31:0] got;
    addrs = '{10'd0, 10'd1, 10'd37, 10'd255, 10'd512, 10'd700, 10'd1022, 10'd1023};
    for (int i = 0; i < 8; i++) begin
      data[i] = next_random();
      bus_put({1'b0, addrs[i]}, data[i]);
    end
    for (int i = 0; i < 8; i++) begin
      bus_get({1'b0, addrs[i]}, got);
      check_value("bus_dout", got, data[i]);
    end
  endtask

  task automatic test_to_drive();
    logic [15:0] got;
    for (int k = 0; k < 64; k++) begin
      bus_words[k] = next_random();
      bus_put({1'b0, k[9:0]}, bus_words[k]);
    end
    u_model.reset_index();
    start_transfer(128, ata_pkg::DIR_TO_DRIVE);
    wait_idle();
    check_value("words at drive", 32'(u_model.words_written()), 32'd128);
    for (int k = 0; k < 64; k++) begin
      got = u_model.stored_word(2 * k);
      check_value("drive word even", 32'(got), 32'(swap_bytes(bus_words[k][31:16])));
      got = u_model.stored_word(2 * k + 1);
      check_value("drive word odd", 32'(got), 32'(swap_bytes(bus_words[k][15:0])));
    end
  endtask

  task automatic test_from_drive();
    logic [31:0] r;
    logic [31:0] got;
    for (int i = 0; i < 128; i++) begin
      r = next_random();
      drive_words[i] = r[15:0];
      u_model.load_word(i, r[15:0]);
    end
    u_model.reset_index();
    start_transfer(128, ata_pkg::DIR_FROM_DRIVE);
    wait_idle();
    check_value("words from drive", 32'(u_model.words_read()), 32'd128);
    for (int k = 0; k < 64; k++) begin
      bus_get({1'b0, k[9:0]}, got);
      check_value("bus_dout", got,
                  {swap_bytes(drive_words[2 * k]), swap_bytes(drive_words[2 * k + 1])});
    end
  endtask

  task automatic test_status();
    logic [31:0] st;
    int          strobes_before;
    bus_get(reg_addr(bus_pkg::REG_STATUS), st);
    check_value("status", st, 32'h2); // done left over from the previous transfer
    bus_put(reg_addr(bus_pkg::REG_STATUS), 32'h0);
    bus_get(reg_addr(bus_pkg::REG_STATUS), st);
    check_value("status", st, 32'h0);
    u_model.reset_index();
    strobes_before = wr_strobes;
    start_transfer(16, ata_pkg::DIR_TO_DRIVE);
    bus_get(reg_addr(bus_pkg::REG_STATUS), st);
    check_value("status", st, 32'h1);
    bus_put(reg_addr(bus_pkg::REG_CTRL), 32'h3); // ignored while busy
    wait_idle();
    repeat (20) @(negedge clk);
    check_value("words at drive", 32'(u_model.words_written()), 32'd16);
    check_value("diow_n strobes", 32'(wr_strobes - strobes_before), 32'd16);
    bus_get(reg_addr(bus_pkg::REG_STATUS), st);
    check_value("status", st, 32'h2);
    bus_put(reg_addr(bus_pkg::REG_STATUS), 32'h0);
    bus_get(reg_addr(bus_pkg::REG_STATUS), st);
    check_value("status", st, 32'h0);
  endtask

  initial begin
    arst_n    = 1'b0;
    bus_en    = 1'b0;
    bus_write = 1'b0;
    bus_addr  = '0;
    bus_din   = '0;
    repeat (10) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    test_reset_state();
    test_buffer_round_trip();
    test_to_drive();
    test_from_drive();
    test_status();
    $display("Everything OK");
    $finish;
  end

endmodule

//--- build.f
+incdir+include
design/bus_pkg.sv
design/ata_pkg.sv
design/ata_buf_if.sv
design/ata_cfg_if.sv
design/ata_buffer.sv
design/ata_regs.sv
design/ata_pio_xfer.sv
design/ata_ctrl_top.sv
sim/ata_drive_model.sv
sim/tb_ata_ctrl.sv

//--- Makefile
# Verilator build and run of the ATA host controller testbench

TOP = tb_ata_ctrl

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f build.f --top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Everything OK$$"

clean:
	rm -rf obj_dir
